//--- source/axiTypesPkg.sv
package axiTypesPkg;

    ////////////////////
    // Field widths
    ////////////////////
    localparam int ADDR_W = 32;

    typedef logic [ADDR_W-1:0] addrT;
    typedef logic [63:0]       mDataT;
    typedef logic [31:0]       sDataT;
    typedef logic [7:0]        mStrbT;
    typedef logic [3:0]        sStrbT;
    typedef logic [7:0]        lenT;
    typedef logic [2:0]        sizeT;
    typedef logic [1:0]        burstT;
    typedef logic [1:0]        respT;

    ////////////////////
    // Protocol codes
    ////////////////////
    localparam burstT BURST_INCR = 2'b01;

    // Ordered by severity, so the merge takes the larger code
    localparam respT RESP_OKAY   = 2'b00;
    localparam respT RESP_EXOKAY = 2'b01;
    localparam respT RESP_SLVERR = 2'b10;
    localparam respT RESP_DECERR = 2'b11;

    localparam sizeT MASTER_SIZE = 3'd3;
    localparam sizeT SLAVE_SIZE  = 3'd2;

endpackage

//--- source/dwcCtrlPkg.sv
package dwcCtrlPkg;

    // Address channel split machine
    typedef enum logic [1:0]
    {
        SPLIT_IDLE,
        SPLIT_FIRST,
        SPLIT_SECOND
    } splitStateT;

    // Which half of the master beat goes out next
    typedef enum logic
    {
        HALF_LOW,
        HALF_HIGH
    } halfT;

    // Longest slave burst, as an AXI length field
    localparam int unsigned MAX_SLAVE_LEN = 255;

    // 256 slave beats of 4 bytes each
    localparam int unsigned PIECE_BYTES = 1024;

endpackage

//--- source/cmdFifo.sv
`timescale 1ns/1ps

module cmdFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             ACLK,
    input  logic             rstN,
    input  logic             push,
    input  logic [WIDTH-1:0] pushData,
    input  logic             pop,
    output logic [WIDTH-1:0] popData,
    output logic             empty,
    output logic             nearlyFull
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head entry shows without a read cycle
    assign popData    = mem[rdPtr];
    assign empty      = (count == '0);
    assign nearlyFull = (count >= CNT_W'(DEPTH - 1));

    always_ff @(posedge ACLK)
    begin
        if (push)
        begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
            begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop)
            begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    noOverflow: assert property (@(posedge ACLK) disable iff (!rstN)
        push |-> (count < CNT_W'(DEPTH)))
        else $error("cmdFifo push while full");

    noUnderflow: assert property (@(posedge ACLK) disable iff (!rstN)
        pop |-> !empty)
        else $error("cmdFifo pop while empty");

endmodule

//--- source/awSplitter.sv
`timescale 1ns/1ps

module awSplitter
    import axiTypesPkg::*;
    import dwcCtrlPkg::*;
#(
    parameter int ID_WIDTH = 2,
    localparam int NUM_IDS = 2 ** ID_WIDTH
) (
    input  logic                ACLK,
    input  logic                rstN,
    input  logic                masterAwValid,
    input  addrT                masterAwAddr,
    input  lenT                 masterAwLen,
    input  sizeT                masterAwSize,
    input  burstT               masterAwBurst,
    input  logic [ID_WIDTH-1:0] masterAwId,
    input  logic                slaveAwReady,
    input  logic                wCmdNearlyFull,
    input  logic [NUM_IDS-1:0]  trackNearlyFull,
    output logic                masterAwReady,
    output logic                slaveAwValid,
    output addrT                slaveAwAddr,
    output lenT                 slaveAwLen,
    output sizeT                slaveAwSize,
    output burstT               slaveAwBurst,
    output logic [ID_WIDTH-1:0] slaveAwId,
    output logic                wCmdPush,
    output lenT                 wCmdLen,
    output logic [NUM_IDS-1:0]  trackPush,
    output logic                trackLast
);

    splitStateT          state;
    addrT                cmdAddr;
    logic [ID_WIDTH-1:0] cmdId;
    logic [8:0]          totalLenM1;   // slave beats minus one, up to 511
    logic                twoPiece;
    logic                pieceDone;

    ////////////////////
    // Master side
    ////////////////////
    // Both queues need room for two pieces before a burst is taken
    assign masterAwReady = (state == SPLIT_IDLE) && !wCmdNearlyFull &&
                           !trackNearlyFull[masterAwId];

    always_ff @(posedge ACLK)
    begin
        if (masterAwValid && masterAwReady)
        begin
            cmdAddr    <= masterAwAddr;
            cmdId      <= masterAwId;
            totalLenM1 <= {masterAwLen, 1'b1};
        end
    end

    ////////////////////
    // Slave side
    ////////////////////
    assign twoPiece  = (totalLenM1 > 9'(MAX_SLAVE_LEN));
    assign pieceDone = slaveAwValid && slaveAwReady;

    assign slaveAwValid = (state != SPLIT_IDLE);
    assign slaveAwId    = cmdId;
    assign slaveAwSize  = SLAVE_SIZE;
    assign slaveAwBurst = BURST_INCR;
    assign slaveAwAddr  = (state == SPLIT_SECOND) ? cmdAddr + addrT'(PIECE_BYTES) : cmdAddr;

    // The second piece drops 256 beats, which only clears bit 8
    assign slaveAwLen = (state == SPLIT_FIRST && twoPiece) ? lenT'(MAX_SLAVE_LEN)
                                                           : totalLenM1[7:0];

    // Bookkeeping goes out with each piece
    assign wCmdPush  = pieceDone;
    assign wCmdLen   = slaveAwLen;
    assign trackLast = (state == SPLIT_SECOND) || !twoPiece;

    always_comb
    begin
        trackPush = '0;
        if (pieceDone)
        begin
            trackPush[cmdId] = 1'b1;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (!rstN)
        begin
            state <= SPLIT_IDLE;
        end
        else
        begin
            case (state)
                SPLIT_IDLE:
                begin
                    if (masterAwValid && masterAwReady)
                    begin
                        state <= SPLIT_FIRST;
                    end
                end
                SPLIT_FIRST:
                begin
                    if (slaveAwReady)
                    begin
                        state <= twoPiece ? SPLIT_SECOND : SPLIT_IDLE;
                    end
                end
                SPLIT_SECOND:
                begin
                    if (slaveAwReady)
                    begin
                        state <= SPLIT_IDLE;
                    end
                end
                default: state <= SPLIT_IDLE;
            endcase
        end
    end

    awStable: assert property (@(posedge ACLK) disable iff (!rstN)
        slaveAwValid && !slaveAwReady |=> slaveAwValid && $stable(slaveAwAddr) &&
        $stable(slaveAwLen) && $stable(slaveAwId))
        else $error("slave AW changed under back-pressure");

    awLegal: assert property (@(posedge ACLK) disable iff (!rstN)
        masterAwValid && masterAwReady |->
        masterAwSize == MASTER_SIZE && masterAwBurst == BURST_INCR)
        else $error("master burst is not full-width INCR");

endmodule

//--- source/wDownsizer.sv
`timescale 1ns/1ps

module wDownsizer
    import axiTypesPkg::*;
    import dwcCtrlPkg::*;
(
    input  logic  ACLK,
    input  logic  rstN,
    input  lenT   wCmdLen,
    input  logic  wCmdEmpty,
    input  logic  masterWValid,
    input  mDataT masterWData,
    input  mStrbT masterWStrb,
    input  logic  slaveWReady,
    output logic  wCmdPop,
    output logic  masterWReady,
    output logic  slaveWValid,
    output sDataT slaveWData,
    output sStrbT slaveWStrb,
    output logic  slaveWLast
);

    halfT half;
    lenT  beatCnt;   // slave beats sent in the current piece
    logic slaveBeat;

    ////////////////////
    // Data path
    ////////////////////
    assign slaveWData = (half == HALF_HIGH) ? masterWData[63:32] : masterWData[31:0];
    assign slaveWStrb = (half == HALF_HIGH) ? masterWStrb[7:4] : masterWStrb[3:0];

    // No piece queued means no slave beat, whatever the master offers
    assign slaveWValid = masterWValid && !wCmdEmpty;
    assign slaveBeat   = slaveWValid && slaveWReady;

    // Master beat retires with its upper half
    assign masterWReady = (half == HALF_HIGH) && slaveWReady;

    assign slaveWLast = (beatCnt == wCmdLen);
    assign wCmdPop    = slaveBeat && slaveWLast;

    ////////////////////
    // Beat tracking
    ////////////////////
    always_ff @(posedge ACLK)
    begin
        if (!rstN)
        begin
            half    <= HALF_LOW;
            beatCnt <= '0;
        end
        else if (slaveBeat)
        begin
            half <= (half == HALF_LOW) ? HALF_HIGH : HALF_LOW;
            if (slaveWLast)
            begin
                beatCnt <= '0;
            end
            else
            begin
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

endmodule

//--- source/brespTracker.sv
`timescale 1ns/1ps

module brespTracker
    import axiTypesPkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic ACLK,
    input  logic rstN,
    input  logic push,
    input  logic lastIn,
    input  logic pop,
    input  respT slaveBResp,
    output logic nearlyFull,
    output logic empty,
    output logic headLast,
    output respT mergedResp
);

    respT storedResp;   // worst code seen so far in the open burst

    // One flag per outstanding piece of this ID
    cmdFifo #(
        .WIDTH (1),
        .DEPTH (FIFO_DEPTH)
    ) flagFifo (
        .ACLK       (ACLK),
        .rstN       (rstN),
        .push       (push),
        .pushData   (lastIn),
        .pop        (pop),
        .popData    (headLast),
        .empty      (empty),
        .nearlyFull (nearlyFull)
    );

    assign mergedResp = (slaveBResp > storedResp) ? slaveBResp : storedResp;

    always_ff @(posedge ACLK)
    begin
        if (!rstN)
        begin
            storedResp <= RESP_OKAY;
        end
        else if (pop)
        begin
            // Closing piece starts the next burst clean
            storedResp <= headLast ? RESP_OKAY : mergedResp;
        end
    end

endmodule

//--- source/brespMerge.sv
`timescale 1ns/1ps

module brespMerge
    import axiTypesPkg::*;
#(
    parameter int ID_WIDTH = 2,
    localparam int NUM_IDS = 2 ** ID_WIDTH
) (
    input  logic                ACLK,
    input  logic                rstN,
    input  logic                slaveBValid,
    input  logic [ID_WIDTH-1:0] slaveBId,
    input  respT                slaveBResp,
    input  logic [NUM_IDS-1:0]  headLast,
    input  respT [NUM_IDS-1:0]  mergedResp,
    input  logic [NUM_IDS-1:0]  trackEmpty,
    input  logic                masterBReady,
    output logic                slaveBReady,
    output logic [NUM_IDS-1:0]  trackPop,
    output logic                masterBValid,
    output logic [ID_WIDTH-1:0] masterBId,
    output respT                masterBResp
);

    logic slaveBDone;
    logic burstDone;

    // Stall the slave while a merged response waits
    assign slaveBReady = !masterBValid;
    assign slaveBDone  = slaveBValid && slaveBReady;
    assign burstDone   = slaveBDone && headLast[slaveBId];

    always_comb
    begin
        trackPop = '0;
        if (slaveBDone)
        begin
            trackPop[slaveBId] = 1'b1;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (!rstN)
        begin
            masterBValid <= 1'b0;
        end
        else if (burstDone)
        begin
            masterBValid <= 1'b1;
        end
        else if (masterBReady)
        begin
            masterBValid <= 1'b0;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (burstDone)
        begin
            masterBId   <= slaveBId;
            masterBResp <= mergedResp[slaveBId];
        end
    end

    bKnownId: assert property (@(posedge ACLK) disable iff (!rstN)
        slaveBDone |-> !trackEmpty[slaveBId])
        else $error("slave B for an ID with nothing outstanding: %0d", slaveBId);

endmodule

//--- source/axiWriteDownsizer.sv
`timescale 1ns/1ps

module axiWriteDownsizer
    import axiTypesPkg::*;
#(
    parameter int ID_WIDTH   = 2,
    parameter int FIFO_DEPTH = 4,
    localparam int NUM_IDS   = 2 ** ID_WIDTH
) (
    input  logic                ACLK,
    input  logic                rstN,
    input  logic                masterAwValid,
    input  addrT                masterAwAddr,
    input  lenT                 masterAwLen,
    input  sizeT                masterAwSize,
    input  burstT               masterAwBurst,
    input  logic [ID_WIDTH-1:0] masterAwId,
    input  logic                slaveAwReady,
    input  logic                masterWValid,
    input  mDataT               masterWData,
    input  mStrbT               masterWStrb,
    input  logic                slaveWReady,
    input  logic                slaveBValid,
    input  logic [ID_WIDTH-1:0] slaveBId,
    input  respT                slaveBResp,
    input  logic                masterBReady,
    output logic                masterAwReady,
    output logic                slaveAwValid,
    output addrT                slaveAwAddr,
    output lenT                 slaveAwLen,
    output sizeT                slaveAwSize,
    output burstT               slaveAwBurst,
    output logic [ID_WIDTH-1:0] slaveAwId,
    output logic                masterWReady,
    output logic                slaveWValid,
    output sDataT               slaveWData,
    output sStrbT               slaveWStrb,
    output logic                slaveWLast,
    output logic                slaveBReady,
    output logic                masterBValid,
    output logic [ID_WIDTH-1:0] masterBId,
    output respT                masterBResp
);

    logic               wCmdPush;
    lenT                wCmdPushLen;
    lenT                wCmdLen;
    logic               wCmdPop;
    logic               wCmdEmpty;
    logic               wCmdNearlyFull;
    logic [NUM_IDS-1:0] trackPush;
    logic               trackLast;
    logic [NUM_IDS-1:0] trackPop;
    logic [NUM_IDS-1:0] trackNearlyFull;
    logic [NUM_IDS-1:0] trackEmpty;
    logic [NUM_IDS-1:0] headLast;
    respT [NUM_IDS-1:0] mergedResp;

    ////////////////////
    // Address and data
    ////////////////////
    awSplitter #(
        .ID_WIDTH (ID_WIDTH)
    ) awSplit (
        .ACLK            (ACLK),
        .rstN            (rstN),
        .masterAwValid   (masterAwValid),
        .masterAwAddr    (masterAwAddr),
        .masterAwLen     (masterAwLen),
        .masterAwSize    (masterAwSize),
        .masterAwBurst   (masterAwBurst),
        .masterAwId      (masterAwId),
        .slaveAwReady    (slaveAwReady),
        .wCmdNearlyFull  (wCmdNearlyFull),
        .trackNearlyFull (trackNearlyFull),
        .masterAwReady   (masterAwReady),
        .slaveAwValid    (slaveAwValid),
        .slaveAwAddr     (slaveAwAddr),
        .slaveAwLen      (slaveAwLen),
        .slaveAwSize     (slaveAwSize),
        .slaveAwBurst    (slaveAwBurst),
        .slaveAwId       (slaveAwId),
        .wCmdPush        (wCmdPush),
        .wCmdLen         (wCmdPushLen),
        .trackPush       (trackPush),
        .trackLast       (trackLast)
    );

    // Piece lengths in issue order
    cmdFifo #(
        .WIDTH ($bits(lenT)),
        .DEPTH (FIFO_DEPTH)
    ) wCmdFifo (
        .ACLK       (ACLK),
        .rstN       (rstN),
        .push       (wCmdPush),
        .pushData   (wCmdPushLen),
        .pop        (wCmdPop),
        .popData    (wCmdLen),
        .empty      (wCmdEmpty),
        .nearlyFull (wCmdNearlyFull)
    );

    wDownsizer wDown (
        .ACLK         (ACLK),
        .rstN         (rstN),
        .wCmdLen      (wCmdLen),
        .wCmdEmpty    (wCmdEmpty),
        .masterWValid (masterWValid),
        .masterWData  (masterWData),
        .masterWStrb  (masterWStrb),
        .slaveWReady  (slaveWReady),
        .wCmdPop      (wCmdPop),
        .masterWReady (masterWReady),
        .slaveWValid  (slaveWValid),
        .slaveWData   (slaveWData),
        .slaveWStrb   (slaveWStrb),
        .slaveWLast   (slaveWLast)
    );

    ////////////////////
    // Responses
    ////////////////////
    // Independent tracker per ID lets IDs complete out of order
    for (genvar i = 0; i < NUM_IDS; i++)
    begin : gTracker
        brespTracker #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) tracker (
            .ACLK       (ACLK),
            .rstN       (rstN),
            .push       (trackPush[i]),
            .lastIn     (trackLast),
            .pop        (trackPop[i]),
            .slaveBResp (slaveBResp),
            .nearlyFull (trackNearlyFull[i]),
            .empty      (trackEmpty[i]),
            .headLast   (headLast[i]),
            .mergedResp (mergedResp[i])
        );
    end

    brespMerge #(
        .ID_WIDTH (ID_WIDTH)
    ) bMerge (
        .ACLK         (ACLK),
        .rstN         (rstN),
        .slaveBValid  (slaveBValid),
        .slaveBId     (slaveBId),
        .slaveBResp   (slaveBResp),
        .headLast     (headLast),
        .mergedResp   (mergedResp),
        .trackEmpty   (trackEmpty),
        .masterBReady (masterBReady),
        .slaveBReady  (slaveBReady),
        .trackPop     (trackPop),
        .masterBValid (masterBValid),
        .masterBId    (masterBId),
        .masterBResp  (masterBResp)
    );

endmodule

//--- verif/tbWriteDownsizer.sv
`timescale 1ns/1ps

module tbWriteDownsizer
    import axiTypesPkg::*;
();

    // Slave beats over all tests: 8 + 12 + 402 + 284 + at most 4 * 300 random
    localparam int MAX_CYCLES = 4 * 1906 + 200;

    logic ACLK = 1'b0;
    logic rstN;
    logic masterAwValid, masterAwReady, slaveAwValid, slaveAwReady;
    addrT masterAwAddr, slaveAwAddr;
    lenT  masterAwLen, slaveAwLen;
    sizeT masterAwSize, slaveAwSize;
    burstT masterAwBurst, slaveAwBurst;
    logic [1:0] masterAwId, slaveAwId, slaveBId, masterBId;
    logic masterWValid, masterWReady, slaveWValid, slaveWReady, slaveWLast;
    mDataT masterWData;
    mStrbT masterWStrb;
    sDataT slaveWData;
    sStrbT slaveWStrb;
    logic slaveBValid, slaveBReady, masterBValid, masterBReady;
    respT slaveBResp, masterBResp;

    // Expected traffic and the slave's accepted pieces {id, resp}
    addrT awAddrQ[$], mAwAddrQ[$];
    lenT  awLenQ[$], mAwLenQ[$];
    logic [1:0] awIdQ[$], mAwIdQ[$], orderQ[$];
    respT respPlanQ[$];
    logic [36:0] wExpQ[$];
    mDataT mwDataQ[$];
    mStrbT mwStrbQ[$];
    logic [3:0] bExpQ[$], sPieces[$];

    // Queue heads seen by the assertions
    logic awHeadValid, wHeadValid, expBFound;
    addrT expAwAddr;
    lenT expAwLen;
    logic [1:0] expAwId;
    logic [36:0] expW;
    respT expBResp;

    int seed = 32'h1542;
    int cycleCount = 0;
    int awHsCount = 0;
    int bCount = 0;
    logic randomReady = 1'b0;
    string testName = "reset";

    always #2 ACLK = ~ACLK;

    axiWriteDownsizer #(
        .ID_WIDTH   (2),
        .FIFO_DEPTH (4)
    ) i_dut (.*);

    task automatic failRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportValue(input string check, input logic [63:0] expVal, actVal);
        failRun($sformatf("[ERROR] %s, %s: expected %0h, actual %0h",
            testName, check, expVal, actVal));
    endtask

    ////////////////////
    // Checks
    ////////////////////
    awMatch: assert property (@(posedge ACLK) disable iff (!rstN)
        slaveAwValid && slaveAwReady |-> awHeadValid && slaveAwAddr == expAwAddr &&
        slaveAwLen == expAwLen && slaveAwId == expAwId && slaveAwSize == SLAVE_SIZE &&
        slaveAwBurst == BURST_INCR)
        else reportValue("slave AW {id,len,addr}", 64'({expAwId, expAwLen, expAwAddr}),
            64'({$sampled(slaveAwId), $sampled(slaveAwLen), $sampled(slaveAwAddr)}));

    awHold: assert property (@(posedge ACLK) disable iff (!rstN)
        slaveAwValid && !slaveAwReady |=> slaveAwValid && $stable(slaveAwAddr) &&
        $stable(slaveAwLen) && $stable(slaveAwId))
        else failRun("Slave AW changed while it waited for ready");

    wMatch: assert property (@(posedge ACLK) disable iff (!rstN)
        slaveWValid && slaveWReady |-> wHeadValid &&
        {slaveWData, slaveWStrb, slaveWLast} == expW)
        else reportValue("slave W {data,strb,last}", 64'(expW),
            64'({$sampled(slaveWData), $sampled(slaveWStrb), $sampled(slaveWLast)}));

    bMatch: assert property (@(posedge ACLK) disable iff (!rstN)
        masterBValid && masterBReady |-> expBFound && masterBResp == expBResp)
        else reportValue($sformatf("master B resp for ID %0d", $sampled(masterBId)),
            64'(expBResp), 64'($sampled(masterBResp)));

    always @(negedge ACLK)
    begin
        int k;
        awHeadValid = (awAddrQ.size() != 0);
        if (awHeadValid)
        begin
            expAwAddr = awAddrQ[0];
            expAwLen  = awLenQ[0];
            expAwId   = awIdQ[0];
        end
        wHeadValid = (wExpQ.size() != 0);
        if (wHeadValid)
        begin
            expW = wExpQ[0];
        end
        // Oldest open burst of the ID on the master B channel
        expBFound = 1'b0;
        for (k = 0; k < bExpQ.size(); k++)
        begin
            if (!expBFound && bExpQ[k][3:2] == masterBId)
            begin
                expBResp  = bExpQ[k][1:0];
                expBFound = 1'b1;
            end
        end
    end

    always @(posedge ACLK)
    begin
        int k;
        logic hit;
        if (rstN)
        begin
            if (masterAwValid && masterAwReady)
            begin
                awHsCount++;
            end
            if (slaveAwValid && slaveAwReady && awAddrQ.size() != 0)
            begin
                sPieces.push_back({slaveAwId, respPlanQ.pop_front()});
                void'(awAddrQ.pop_front());
                void'(awLenQ.pop_front());
                void'(awIdQ.pop_front());
            end
            if (slaveWValid && slaveWReady && wExpQ.size() != 0)
            begin
                void'(wExpQ.pop_front());
            end
            if (masterBValid && masterBReady)
            begin
                bCount++;
                hit = 1'b0;
                for (k = 0; k < bExpQ.size(); k++)
                begin
                    if (!hit && bExpQ[k][3:2] == masterBId)
                    begin
                        bExpQ.delete(k);
                        hit = 1'b1;
                    end
                end
            end
        end
        cycleCount++;
        if (cycleCount >= MAX_CYCLES)
        begin
            failRun("Timeout: the DUT hung before all tests finished");
        end
    end

    always @(negedge ACLK)
    begin
        if (randomReady)
        begin
            slaveAwReady = 1'($random(seed));
            slaveWReady  = 1'($random(seed));
            masterBReady = 1'($random(seed));
        end
        else
        begin
            slaveAwReady = 1'b1;
            slaveWReady  = 1'b1;
            masterBReady = 1'b1;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////
    task automatic pushPiece(input addrT addr, input lenT len, input logic [1:0] id,
                             input respT resp);
        awAddrQ.push_back(addr);
        awLenQ.push_back(len);
        awIdQ.push_back(id);
        respPlanQ.push_back(resp);
    endtask

    // Queues one master burst and everything it should produce
    task automatic addBurst(input logic [1:0] id, input addrT addr, input lenT len,
                            input respT r1, input respT r2);
        int beats;
        int j;
        mDataT d;
        mStrbT s;
        beats = 2 * (int'(len) + 1);
        mAwAddrQ.push_back(addr);
        mAwLenQ.push_back(len);
        mAwIdQ.push_back(id);
        if (beats <= 256)
        begin
            pushPiece(addr, lenT'(beats - 1), id, r1);
            bExpQ.push_back({id, r1});
        end
        else
        begin
            pushPiece(addr, 8'd255, id, r1);
            pushPiece(addr + 32'd1024, lenT'(beats - 257), id, r2);
            bExpQ.push_back({id, (r1 > r2) ? r1 : r2});
        end
        for (j = 0; j < beats; j += 2)
        begin
            d = {$random(seed), $random(seed)};
            s = mStrbT'($random(seed));
            mwDataQ.push_back(d);
            mwStrbQ.push_back(s);
            // Pieces hold whole master beats, so a low half never closes one
            wExpQ.push_back({d[31:0], s[3:0], 1'b0});
            wExpQ.push_back({d[63:32], s[7:4], j + 1 == beats - 1 || (j == 254 && beats > 256)});
        end
    endtask

    task automatic sendAddrs();
        while (mAwAddrQ.size() != 0)
        begin
            masterAwAddr  = mAwAddrQ.pop_front();
            masterAwLen   = mAwLenQ.pop_front();
            masterAwId    = mAwIdQ.pop_front();
            masterAwValid = 1'b1;
            @(posedge ACLK);
            while (!masterAwReady)
            begin
                @(posedge ACLK);
            end
            @(negedge ACLK);
            masterAwValid = 1'b0;
        end
    endtask

    task automatic sendData();
        while (mwDataQ.size() != 0)
        begin
            masterWData  = mwDataQ.pop_front();
            masterWStrb  = mwStrbQ.pop_front();
            masterWValid = 1'b1;
            @(posedge ACLK);
            while (!masterWReady)
            begin
                @(posedge ACLK);
            end
            @(negedge ACLK);
            masterWValid = 1'b0;
        end
    endtask

    // Slave answers every accepted piece of one ID, oldest first
    task automatic answerId(input logic [1:0] id);
        int k;
        int idx;
        logic found;
        found = 1'b1;
        while (found)
        begin
            found = 1'b0;
            for (k = 0; k < sPieces.size(); k++)
            begin
                if (!found && sPieces[k][3:2] == id)
                begin
                    idx   = k;
                    found = 1'b1;
                end
            end
            if (found)
            begin
                slaveBId    = id;
                slaveBResp  = sPieces[idx][1:0];
                slaveBValid = 1'b1;
                @(posedge ACLK);
                while (!slaveBReady)
                begin
                    @(posedge ACLK);
                end
                sPieces.delete(idx);
                @(negedge ACLK);
                slaveBValid = 1'b0;
            end
        end
    endtask

    task automatic runPhase();
        fork
            sendAddrs();
            sendData();
        join
        while (wExpQ.size() != 0)
        begin
            @(negedge ACLK);
        end
        while (orderQ.size() != 0)
        begin
            answerId(orderQ.pop_front());
        end
        while (bExpQ.size() != 0)
        begin
            @(negedge ACLK);
        end
    endtask

    initial
    begin
        int n;
        rstN = 1'b0;
        masterAwValid = 1'b0;
        masterAwAddr  = '0;
        masterAwLen   = '0;
        masterAwSize  = MASTER_SIZE;
        masterAwBurst = BURST_INCR;
        masterAwId    = '0;
        slaveAwReady  = 1'b1;
        masterWValid  = 1'b0;
        masterWData   = '0;
        masterWStrb   = '0;
        slaveWReady   = 1'b1;
        slaveBValid   = 1'b0;
        slaveBId      = '0;
        slaveBResp    = RESP_OKAY;
        masterBReady  = 1'b1;
        repeat (2) @(negedge ACLK);
        rstN = 1'b1;

        testName = "short burst";
        addBurst(2'd1, 32'h1000, 8'd3, RESP_OKAY, RESP_OKAY);
        orderQ = '{2'd1};
        runPhase();

        testName = "one-piece DECERR";
        addBurst(2'd0, 32'h8000, 8'd5, RESP_DECERR, RESP_OKAY);
        orderQ = '{2'd0};
        runPhase();

        testName = "long burst SLVERR merge";
        addBurst(2'd3, 32'h2000, 8'd200, RESP_SLVERR, RESP_OKAY);
        orderQ = '{2'd3};
        runPhase();

        testName = "out-of-order IDs";
        addBurst(2'd0, 32'h4000, 8'd10, RESP_EXOKAY, RESP_OKAY);
        addBurst(2'd2, 32'h6000, 8'd130, RESP_OKAY, RESP_SLVERR);
        orderQ = '{2'd2, 2'd0};
        runPhase();

        testName = "back-pressure";
        randomReady = 1'b1;
        for (n = 0; n < 4; n++)
        begin
            addBurst(2'(n), addrT'(32'h10000 + n * 32'h1000),
                     lenT'(($random(seed) & 32'h7fff_ffff) % 150),
                     respT'($random(seed)), respT'($random(seed)));
        end
        orderQ = '{2'd3, 2'd1, 2'd2, 2'd0};
        runPhase();

        testName = "response count";
        respCount: assert (bCount == awHsCount)
            else reportValue("master B count", 64'(awHsCount), 64'(bCount));
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- vlog.f
source/axiTypesPkg.sv
source/dwcCtrlPkg.sv
source/cmdFifo.sv
source/awSplitter.sv
source/wDownsizer.sv
source/brespTracker.sv
source/brespMerge.sv
source/axiWriteDownsizer.sv
verif/tbWriteDownsizer.sv

//--- run.sh
#!/bin/sh
# Build and run the downsizer testbench with Verilator
verilator --binary --timing --assert -f vlog.f --top-module tbWriteDownsizer \
    -o simv || { echo "Build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0
